/* design/pool_pkg.sv */
package pool_pkg;

	localparam int FM_DEPTH = 1024;
	localparam int FM_AW = $clog2(FM_DEPTH);

	typedef logic signed [7:0] fm_data_t;
	typedef logic [FM_AW-1:0] fm_addr_t;
	typedef logic [5:0] dim_t;
	typedef logic [7:0] chan_t;
	typedef logic [13:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;

	// control registers, byte addresses
	localparam axil_addr_t REG_CTRL = 14'h000;
	localparam axil_addr_t REG_STATUS = 14'h004;
	localparam axil_addr_t REG_ROWS = 14'h008;
	localparam axil_addr_t REG_CHANNELS = 14'h00c;
	localparam axil_addr_t REG_KERNEL = 14'h010;

	// ram windows, one sample per 32-bit word
	localparam axil_addr_t IN_BASE = 14'h1000;
	localparam axil_addr_t OUT_BASE = 14'h2000;
	localparam axil_addr_t WIN_MASK = 14'h0fff;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// smallest signed sample, seeds the running max
	localparam fm_data_t FM_MIN = 8'sh80;

	typedef enum logic [1:0] {
		st_idle,
		st_read_window,
		st_write_result,
		st_done
	} pool_state_t;

endpackage

/* design/fm_ram.sv */
module fm_ram
	import pool_pkg::*;
(
	input  logic     clk,
	input  logic     ram_en,
	input  logic     ram_we,
	input  fm_addr_t ram_addr,
	input  fm_data_t ram_wdata,
	output fm_data_t ram_rdata
);

	fm_data_t mem [FM_DEPTH];

	// one cycle read latency, output holds during writes
	always_ff @(posedge clk) begin
		if (ram_en) begin
			if (ram_we) begin
				mem[ram_addr] <= ram_wdata;
			end else begin
				ram_rdata <= mem[ram_addr];
			end
		end
	end

endmodule

/* design/pool_host_port.sv */
module pool_host_port
	import pool_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  axil_addr_t awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axil_data_t wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axil_addr_t araddr,
	input  logic       arvalid,
	output logic       arready,
	output axil_data_t rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready,
	output logic       start,
	output dim_t       num_row,
	output chan_t      num_channel,
	output logic       pool_8x8,
	input  logic       busy,
	input  logic       done,
	input  fm_addr_t   eng_in_addr,
	input  logic       eng_in_rd,
	input  fm_addr_t   eng_out_addr,
	input  logic       eng_out_wr,
	input  fm_data_t   eng_out_wdata,
	output logic       in_ram_en,
	output logic       in_ram_we,
	output fm_addr_t   in_ram_addr,
	output fm_data_t   in_ram_wdata,
	input  fm_data_t   in_ram_rdata,
	output logic       out_ram_en,
	output logic       out_ram_we,
	output fm_addr_t   out_ram_addr,
	output fm_data_t   out_ram_wdata,
	input  fm_data_t   out_ram_rdata
);

	logic port_free;
	logic wr_accept;
	logic rd_accept;
	logic rd_pend;
	logic rd_out;
	logic aw_in;
	logic aw_out;
	logic ar_in;
	logic ar_out;
	logic ar_reg;
	logic host_in_en;
	logic host_in_we;
	logic host_out_en;
	fm_addr_t host_addr;
	fm_data_t ram_word;

	// one transaction at a time, writes win a tie
	assign port_free = !bvalid && !rvalid && !rd_pend;
	assign wr_accept = awvalid && wvalid && port_free;
	assign rd_accept = arvalid && port_free && !wr_accept;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign arready = rd_accept;

	assign aw_in = (awaddr & ~WIN_MASK) == IN_BASE;
	assign aw_out = (awaddr & ~WIN_MASK) == OUT_BASE;
	assign ar_in = (araddr & ~WIN_MASK) == IN_BASE;
	assign ar_out = (araddr & ~WIN_MASK) == OUT_BASE;
	assign ar_reg = araddr inside {REG_CTRL, REG_STATUS, REG_ROWS, REG_CHANNELS, REG_KERNEL};

	// host ram access happens in the accept cycle only
	assign host_addr = wr_accept ? fm_addr_t'(awaddr >> 2) : fm_addr_t'(araddr >> 2);
	assign host_in_we = wr_accept && aw_in && wstrb[0];
	assign host_in_en = host_in_we || (rd_accept && ar_in);
	assign host_out_en = rd_accept && ar_out;

	// engine owns both rams while busy
	assign in_ram_en = busy ? eng_in_rd : host_in_en;
	assign in_ram_we = busy ? 1'b0 : host_in_we;
	assign in_ram_addr = busy ? eng_in_addr : host_addr;
	assign in_ram_wdata = fm_data_t'(wdata[7:0]);
	assign out_ram_en = busy ? eng_out_wr : host_out_en;
	assign out_ram_we = busy ? eng_out_wr : 1'b0;
	assign out_ram_addr = busy ? eng_out_addr : host_addr;
	assign out_ram_wdata = eng_out_wdata;

	assign ram_word = rd_out ? out_ram_rdata : in_ram_rdata;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			start <= 1'b0;
			num_row <= '0;
			num_channel <= '0;
			pool_8x8 <= 1'b0;
		end else begin
			start <= 1'b0;
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (wr_accept) begin
				bvalid <= 1'b1;
				bresp <= RESP_OKAY;
				if (aw_in) begin
					if (busy) begin
						bresp <= RESP_SLVERR;
					end
				end else if (aw_out) begin
					bresp <= RESP_SLVERR;
				end else begin
					case (awaddr)
						// start while busy is dropped silently
						REG_CTRL: start <= wstrb[0] && wdata[0] && !busy;
						REG_ROWS: if (wstrb[0]) num_row <= dim_t'(wdata);
						REG_CHANNELS: if (wstrb[0]) num_channel <= chan_t'(wdata);
						REG_KERNEL: if (wstrb[0]) pool_8x8 <= wdata[0];
						default: bresp <= RESP_SLVERR;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rvalid <= 1'b0;
			rresp <= RESP_OKAY;
			rd_pend <= 1'b0;
			rd_out <= 1'b0;
		end else begin
			rd_pend <= 1'b0;
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			// ram data lands one cycle after the accept
			if (rd_pend) begin
				rvalid <= 1'b1;
				rresp <= RESP_OKAY;
			end
			if (rd_accept) begin
				if (ar_in || ar_out) begin
					if (busy) begin
						rvalid <= 1'b1;
						rresp <= RESP_SLVERR;
					end else begin
						rd_pend <= 1'b1;
						rd_out <= ar_out;
					end
				end else begin
					rvalid <= 1'b1;
					rresp <= ar_reg ? RESP_OKAY : RESP_SLVERR;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_pend) begin
			rdata <= {{24{ram_word[7]}}, ram_word};
		end else if (rd_accept) begin
			case (araddr)
				REG_STATUS: rdata <= {30'b0, done, busy};
				REG_ROWS: rdata <= axil_data_t'(num_row);
				REG_CHANNELS: rdata <= axil_data_t'(num_channel);
				REG_KERNEL: rdata <= axil_data_t'(pool_8x8);
				default: rdata <= '0;
			endcase
		end
	end

endmodule

/* design/max_pool_engine.sv */
module max_pool_engine
	import pool_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  dim_t     num_row,
	input  chan_t    num_channel,
	input  logic     pool_8x8,
	output logic     busy,
	output logic     done,
	output fm_addr_t in_addr,
	output logic     in_rd,
	input  fm_data_t in_rdata,
	output fm_addr_t out_addr,
	output logic     out_wr,
	output fm_data_t out_wdata
);

	pool_state_t state;
	pool_state_t next_state;

	// shape captured at start
	dim_t rows;
	chan_t chans;
	logic big;

	chan_t ch;
	dim_t oy;
	dim_t ox;
	logic [6:0] pos;
	fm_data_t run_max;

	logic [6:0] last_pos;
	dim_t wins;
	dim_t wy;
	dim_t wx;
	dim_t row_y;
	dim_t col_x;
	logic [11:0] plane;
	logic [19:0] addr_full;
	logic last_col;
	logic last_row;
	logic last_chan;
	logic window_end;

	// k*k reads plus one cycle for the last sample to return
	assign last_pos = big ? 7'd64 : 7'd4;
	assign window_end = (pos == last_pos);
	assign wins = big ? (rows >> 3) : (rows >> 1);

	// position inside the window
	assign wy = big ? dim_t'(pos[5:3]) : dim_t'(pos[1]);
	assign wx = big ? dim_t'(pos[2:0]) : dim_t'(pos[0]);
	assign row_y = big ? ({oy[2:0], 3'b000} | wy) : ({oy[4:0], 1'b0} | wy);
	assign col_x = big ? ({ox[2:0], 3'b000} | wx) : ({ox[4:0], 1'b0} | wx);

	// c*R*R + y*R + x
	assign plane = 12'(rows) * 12'(rows);
	assign addr_full = 20'(ch) * 20'(plane) + 20'(row_y) * 20'(rows) + 20'(col_x);
	assign in_addr = fm_addr_t'(addr_full);

	assign last_col = (ox == wins - dim_t'(1));
	assign last_row = (oy == wins - dim_t'(1));
	assign last_chan = (ch == chans - chan_t'(1));

	assign busy = (state == st_read_window) || (state == st_write_result);
	assign done = (state == st_done);
	assign in_rd = (state == st_read_window) && !window_end;
	assign out_wr = (state == st_write_result);
	assign out_wdata = run_max;

	always_comb begin
		next_state = state;
		case (state)
			st_idle, st_done: begin
				if (start) begin
					next_state = st_read_window;
				end
			end
			st_read_window: begin
				if (window_end) begin
					next_state = st_write_result;
				end
			end
			st_write_result: begin
				if (last_col && last_row && last_chan) begin
					next_state = st_done;
				end else begin
					next_state = st_read_window;
				end
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rows <= '0;
			chans <= '0;
			big <= 1'b0;
			ch <= '0;
			oy <= '0;
			ox <= '0;
			pos <= '0;
			out_addr <= '0;
		end else if ((state == st_idle || state == st_done) && start) begin
			rows <= num_row;
			chans <= num_channel;
			big <= pool_8x8;
			ch <= '0;
			oy <= '0;
			ox <= '0;
			pos <= '0;
			out_addr <= '0;
		end else if (state == st_read_window) begin
			pos <= window_end ? 7'd0 : pos + 7'd1;
		end else if (state == st_write_result) begin
			// outputs are produced in address order
			out_addr <= out_addr + fm_addr_t'(1);
			if (!last_col) begin
				ox <= ox + dim_t'(1);
			end else begin
				ox <= '0;
				if (!last_row) begin
					oy <= oy + dim_t'(1);
				end else begin
					oy <= '0;
					ch <= ch + chan_t'(1);
				end
			end
		end
	end

	// sample for pos p arrives at pos p+1
	always_ff @(posedge clk) begin
		if (state == st_read_window) begin
			if (pos == 7'd0) begin
				run_max <= FM_MIN;
			end else if (in_rdata > run_max) begin
				run_max <= in_rdata;
			end
		end
	end

endmodule

/* design/pool_top.sv */
module pool_top
	import pool_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  axil_addr_t awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axil_data_t wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axil_addr_t araddr,
	input  logic       arvalid,
	output logic       arready,
	output axil_data_t rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready
);

	logic start;
	dim_t num_row;
	chan_t num_channel;
	logic pool_8x8;
	logic busy;
	logic done;

	fm_addr_t eng_in_addr;
	logic eng_in_rd;
	fm_addr_t eng_out_addr;
	logic eng_out_wr;
	fm_data_t eng_out_wdata;

	logic in_ram_en;
	logic in_ram_we;
	fm_addr_t in_ram_addr;
	fm_data_t in_ram_wdata;
	fm_data_t in_ram_rdata;
	logic out_ram_en;
	logic out_ram_we;
	fm_addr_t out_ram_addr;
	fm_data_t out_ram_wdata;
	fm_data_t out_ram_rdata;

	pool_host_port host_i (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.start(start),
		.num_row(num_row),
		.num_channel(num_channel),
		.pool_8x8(pool_8x8),
		.busy(busy),
		.done(done),
		.eng_in_addr(eng_in_addr),
		.eng_in_rd(eng_in_rd),
		.eng_out_addr(eng_out_addr),
		.eng_out_wr(eng_out_wr),
		.eng_out_wdata(eng_out_wdata),
		.in_ram_en(in_ram_en),
		.in_ram_we(in_ram_we),
		.in_ram_addr(in_ram_addr),
		.in_ram_wdata(in_ram_wdata),
		.in_ram_rdata(in_ram_rdata),
		.out_ram_en(out_ram_en),
		.out_ram_we(out_ram_we),
		.out_ram_addr(out_ram_addr),
		.out_ram_wdata(out_ram_wdata),
		.out_ram_rdata(out_ram_rdata)
	);

	max_pool_engine engine_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.num_row(num_row),
		.num_channel(num_channel),
		.pool_8x8(pool_8x8),
		.busy(busy),
		.done(done),
		.in_addr(eng_in_addr),
		.in_rd(eng_in_rd),
		.in_rdata(in_ram_rdata),
		.out_addr(eng_out_addr),
		.out_wr(eng_out_wr),
		.out_wdata(eng_out_wdata)
	);

	fm_ram in_ram (
		.clk(clk),
		.ram_en(in_ram_en),
		.ram_we(in_ram_we),
		.ram_addr(in_ram_addr),
		.ram_wdata(in_ram_wdata),
		.ram_rdata(in_ram_rdata)
	);

	fm_ram out_ram (
		.clk(clk),
		.ram_en(out_ram_en),
		.ram_we(out_ram_we),
		.ram_addr(out_ram_addr),
		.ram_wdata(out_ram_wdata),
		.ram_rdata(out_ram_rdata)
	);

endmodule

/* testbench/tb_pool_top.sv */
module tb_pool_top
	import pool_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD = 40;
	localparam int HALF = PERIOD / 2;
	localparam int QUARTER = PERIOD / 4;

	// worst case of k*k+2 cycles per window summed over every engine run
	localparam int WINDOW_CYCLES = 48 * 6 + 2 * 8 * 66 + 4 * 6;
	// about a thousand transfers of up to twelve cycles each
	localparam int XFER_CYCLES = 1000 * 12;
	localparam int WATCHDOG_CYCLES = 2 * WINDOW_CYCLES + XFER_CYCLES;

	logic clk;
	logic rst;
	axil_addr_t awaddr;
	logic awvalid;
	logic awready;
	axil_data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	axil_addr_t araddr;
	logic arvalid;
	logic arready;
	axil_data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] lfsr;
	int err_count;
	int check_count;
	bit random_hold;
	fm_data_t in_q[$];
	fm_data_t exp_q[$];

	// debug only
	pool_state_t eng_state;
	assign eng_state = pool_top_i.engine_i.state;

	pool_top pool_top_i (.*);

	always #(HALF) clk = ~clk;

	// a response stays put until the master takes it
	b_hold: assert property (@(posedge clk) disable iff (!rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else begin
		err_count++;
		$display("write response dropped or changed before bready at %0t", $time);
	end

	r_hold: assert property (@(posedge clk) disable iff (!rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else begin
		err_count++;
		$display("read response dropped or changed before rready at %0t", $time);
	end

	b_once: assert property (@(posedge clk) disable iff (!rst) bvalid && bready |=> !bvalid)
	else begin
		err_count++;
		$display("write response delivered twice at %0t", $time);
	end

	r_once: assert property (@(posedge clk) disable iff (!rst) rvalid && rready |=> !rvalid)
	else begin
		err_count++;
		$display("read response delivered twice at %0t", $time);
	end

	aw_w_pair: assert property (@(posedge clk) disable iff (!rst)
		(awready == wready) && (!awready || (awvalid && wvalid)) && (!arready || arvalid))
	else begin
		err_count++;
		$display("ready pulse without matching valid at %0t", $time);
	end

	one_open: assert property (@(posedge clk) disable iff (!rst) !(bvalid && rvalid))
	else begin
		err_count++;
		$display("two responses open at once at %0t", $time);
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic axil_data_t sign_extend(input fm_data_t v);
		return {{24{v[7]}}, v};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected)
		else begin
			err_count++;
			$display("Fail %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
			output logic [1:0] resp);
		int hold;
		hold = random_hold ? int'(rand_bits(3)) : 0;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (hold == 0);
		#(QUARTER);
		while (!awready) begin
			@(negedge clk);
			#(QUARTER);
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		#(QUARTER);
		while (!bvalid) begin
			@(negedge clk);
			#(QUARTER);
		end
		resp = bresp;
		if (hold > 0) begin
			repeat (hold) @(negedge clk);
			bready = 1'b1;
		end
	endtask

	task automatic axi_read(input axil_addr_t addr, output axil_data_t data,
			output logic [1:0] resp);
		int hold;
		hold = random_hold ? int'(rand_bits(3)) : 0;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		rready = (hold == 0);
		#(QUARTER);
		while (!arready) begin
			@(negedge clk);
			#(QUARTER);
		end
		@(negedge clk);
		arvalid = 1'b0;
		#(QUARTER);
		while (!rvalid) begin
			@(negedge clk);
			#(QUARTER);
		end
		data = rdata;
		resp = rresp;
		if (hold > 0) begin
			repeat (hold) @(negedge clk);
			rready = 1'b1;
		end
	endtask

	task automatic reg_write(input axil_addr_t addr, input axil_data_t data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_value("bresp", 32'(RESP_OKAY), 32'(resp));
	endtask

	task automatic reg_read_check(input string name, input axil_addr_t addr,
			input axil_data_t expected);
		axil_data_t d;
		logic [1:0] resp;
		axi_read(addr, d, resp);
		check_value("rresp", 32'(RESP_OKAY), 32'(resp));
		check_value(name, expected, d);
	endtask

	task automatic expect_write_error(input axil_addr_t addr, input axil_data_t data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_value("bresp", 32'(RESP_SLVERR), 32'(resp));
	endtask

	task automatic expect_read_error(input axil_addr_t addr);
		axil_data_t d;
		logic [1:0] resp;
		axi_read(addr, d, resp);
		check_value("rresp", 32'(RESP_SLVERR), 32'(resp));
	endtask

	// random map with the first window of channel 0 all negative
	task automatic load_map(input int rows, input int chans, input int k);
		fm_data_t s;
		int a;
		in_q.delete();
		for (a = 0; a < rows * rows * chans; a++) begin
			s = fm_data_t'(rand_bits(8));
			if (a < rows * rows && a / rows < k && a % rows < k) begin
				s[7] = 1'b1;
			end
			in_q.push_back(s);
			reg_write(axil_addr_t'(IN_BASE + 4 * a), {24'h0, s});
		end
	endtask

	task automatic build_expected(input int rows, input int chans, input int k);
		int c;
		int oy;
		int ox;
		int dy;
		int dx;
		fm_data_t m;
		fm_data_t s;
		exp_q.delete();
		for (c = 0; c < chans; c++) begin
			for (oy = 0; oy < rows / k; oy++) begin
				for (ox = 0; ox < rows / k; ox++) begin
					m = fm_data_t'(-128);
					for (dy = 0; dy < k; dy++) begin
						for (dx = 0; dx < k; dx++) begin
							s = in_q[c * rows * rows + (oy * k + dy) * rows + ox * k + dx];
							if (s > m) begin
								m = s;
							end
						end
					end
					exp_q.push_back(m);
				end
			end
		end
	endtask

	task automatic wait_done();
		axil_data_t d;
		logic [1:0] resp;
		d = '0;
		while (!d[1]) begin
			axi_read(REG_STATUS, d, resp);
		end
		check_value("status", 32'h2, d);
	endtask

	task automatic check_outputs();
		axil_data_t d;
		logic [1:0] resp;
		int i;
		for (i = 0; i < exp_q.size(); i++) begin
			axi_read(axil_addr_t'(OUT_BASE + 4 * i), d, resp);
			check_value("rresp", 32'(RESP_OKAY), 32'(resp));
			check_value($sformatf("out[%0d]", i), sign_extend(exp_q[i]), d);
		end
	endtask

	task automatic set_shape(input int rows, input int chans, input bit big);
		reg_write(REG_ROWS, axil_data_t'(rows));
		reg_write(REG_CHANNELS, axil_data_t'(chans));
		reg_write(REG_KERNEL, axil_data_t'(big));
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		lfsr = 32'hf869;
		err_count = 0;
		check_count = 0;
		random_hold = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b1;

		// quiet bus after reset
		repeat (3) begin
			@(negedge clk);
			#(QUARTER);
			check_value("bvalid", 32'h0, 32'(bvalid));
			check_value("rvalid", 32'h0, 32'(rvalid));
			check_value("awready", 32'h0, 32'(awready));
			check_value("arready", 32'h0, 32'(arready));
		end
		reg_read_check("status", REG_STATUS, 32'h0);
		set_shape(8, 3, 1'b0);
		reg_read_check("rows", REG_ROWS, 32'd8);
		reg_read_check("channels", REG_CHANNELS, 32'd3);
		reg_read_check("kernel", REG_KERNEL, 32'd0);
		expect_read_error(14'h020);
		expect_write_error(14'h024, 32'h1);
		expect_write_error(OUT_BASE, 32'h5);

		// 2x2 on 8 rows and 3 channels
		load_map(8, 3, 2);
		build_expected(8, 3, 2);
		reg_read_check("in[0]", IN_BASE, sign_extend(in_q[0]));
		reg_write(REG_CTRL, 32'h1);
		wait_done();
		check_outputs();

		// 8x8 on 16 rows and 2 channels
		set_shape(16, 2, 1'b1);
		load_map(16, 2, 8);
		build_expected(16, 2, 8);
		reg_write(REG_CTRL, 32'h1);
		wait_done();
		check_outputs();

		// restart clears done and the rams are locked out while busy
		reg_write(REG_CTRL, 32'h1);
		reg_read_check("status", REG_STATUS, 32'h1);
		expect_read_error(axil_addr_t'(IN_BASE + 4));
		expect_read_error(OUT_BASE);
		expect_write_error(IN_BASE, ~sign_extend(in_q[0]));
		// kernel change would only show if the busy start restarted the run
		reg_write(REG_KERNEL, 32'h0);
		reg_write(REG_CTRL, 32'h1);
		reg_read_check("status", REG_STATUS, 32'h1);
		wait_done();
		check_outputs();
		reg_read_check("in[0]", IN_BASE, sign_extend(in_q[0]));

		// random back-pressure on every response
		random_hold = 1'b1;
		check_outputs();
		set_shape(4, 1, 1'b0);
		reg_read_check("rows", REG_ROWS, 32'd4);
		load_map(4, 1, 2);
		build_expected(4, 1, 2);
		reg_write(REG_CTRL, 32'h1);
		wait_done();
		check_outputs();
		random_hold = 1'b0;

		$display("checks %0d errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("watchdog expired with engine in state %s", eng_state.name());
		$display("checks %0d errors %0d", check_count, err_count);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* flist.f */
design/pool_pkg.sv
design/fm_ram.sv
design/pool_host_port.sv
design/max_pool_engine.sv
design/pool_top.sv
testbench/tb_pool_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the max-pooling testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

top=tb_pool_top
log=sim.log

rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$top" -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$log"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $log"
	exit 1
fi
